// File: Bender.yml
package:
  name: ffe

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/ffePkg.sv
      - verilog/ffeControl.sv
      - verilog/weightBank.sv
      - verilog/ffe.sv
      - verilog/slicer.sv
      - verilog/ffeTop.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - dv/tbClock.sv
      - dv/ffe_props.sv
      - dv/ffeTb.sv

// File: dv/ffeTb.sv
`timescale 1ns/1ps
`include "ffe_settings.svh"

module ffeTb;

	logic                 clk;
	logic                 rstb;
	ffePkg::codeVec_t     codes;
	ffePkg::weightCmd_t   cmd;
	logic                 credit;
	ffePkg::resultVec_t   eq;
	ffePkg::decisionVec_t decisions;

	// Host-side credit state and bookkeeping
	int cycle;
	int cycleLimit;
	int hostCredits;
	int failures;
	string testName;

	// Pending compares, each due at a fixed slot after its codes went in
	int                   eqDue [$];
	ffePkg::resultVec_t   eqExp [$];
	string                eqName [$];
	int                   decDue [$];
	ffePkg::decisionVec_t decExp [$];
	string                decName [$];

	string traceLines [$];

	tbClock tbClock_i (
		.clk  (clk),
		.rstb (rstb)
	);

	ffeTop ffeTop_i (
		.clk       (clk),
		.rstb      (rstb),
		.codes     (codes),
		.cmd       (cmd),
		.credit    (credit),
		.eq        (eq),
		.decisions (decisions)
	);

	task automatic stopRun();
		failures++;
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic checkEq(input string name, input ffePkg::resultVec_t exp,
			input ffePkg::resultVec_t act);
		if (act !== exp) begin
			$display("Error %s: eq expected %h actual %h", name, exp, act);
			stopRun();
		end
	endtask

	task automatic checkDecisions(input string name, input ffePkg::decisionVec_t exp,
			input ffePkg::decisionVec_t act);
		if (act !== exp) begin
			$display("Error %s: decisions expected %h actual %h", name, exp, act);
			stopRun();
		end
	endtask

	// Compare every result whose slot has come up
	task automatic runDueChecks();
		while (eqDue.size() > 0 && eqDue[0] <= cycle) begin
			void'(eqDue.pop_front());
			checkEq(eqName.pop_front(), eqExp.pop_front(), eq);
		end
		while (decDue.size() > 0 && decDue[0] <= cycle) begin
			void'(decDue.pop_front());
			checkDecisions(decName.pop_front(), decExp.pop_front(), decisions);
		end
	endtask

	// Advance one clock, sample outputs after the edge and reopen the input slot
	task automatic tick();
		@(posedge clk);
		#1;
		cycle++;
		if (cycle > cycleLimit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycleLimit);
			stopRun();
		end
		if (credit) begin
			if (hostCredits >= `CMD_CREDITS) begin
				$display("Credit pulse returned while no command was outstanding");
				stopRun();
			end
			hostCredits++;
		end
		runDueChecks();
		codes = '0;
		cmd   = '0;
	endtask

	task automatic sendCmd(input ffePkg::weightCmd_t c);
		int gap;
		gap = $urandom % 3;
		repeat (gap) tick();
		// Stall while the host has spent all its credits
		while (hostCredits == 0) begin
			tick();
		end
		cmd = c;
		hostCredits--;
		tick();
	endtask

	task automatic drainChecks();
		while (eqDue.size() > 0 || decDue.size() > 0) begin
			tick();
		end
	endtask

	task automatic runLine(input string line);
		byte kind;
		int a;
		int b;
		int w;
		int c [4];
		int e [4];
		int d;
		ffePkg::weightCmd_t nc;
		ffePkg::resultVec_t ev;
		kind = line[0];
		nc = '0;
		case (kind)
			"T": void'($sscanf(line, "%c %s", kind, testName));
			"W": begin
				void'($sscanf(line, "%c %d %d %d", kind, a, b, w));
				nc.valid  = 1'b1;
				nc.op     = ffePkg::OP_WRITE_TAP;
				nc.lane   = a[`LANE_W-1:0];
				nc.tap    = b[`TAP_W-1:0];
				nc.weight = ffePkg::weight_t'(w);
				sendCmd(nc);
			end
			"C": begin
				// Results in flight must not straddle the weight swap
				drainChecks();
				nc.valid = 1'b1;
				nc.op    = ffePkg::OP_COMMIT;
				sendCmd(nc);
				while (hostCredits < `CMD_CREDITS) begin
					tick();
				end
				// Flush the pipeline with zero codes so the new taps see a clean history
				repeat (`SLICE_LATENCY) tick();
			end
			"S": begin
				void'($sscanf(line, "%c %d %d %d %d %d %d %d %d %h", kind,
					c[0], c[1], c[2], c[3], e[0], e[1], e[2], e[3], d));
				for (int j = 0; j < `NUM_CH; j++) begin
					codes[j] = ffePkg::code_t'(c[j]);
					ev[j] = ffePkg::result_t'(e[j]);
				end
				eqDue.push_back(cycle + `FFE_LATENCY);
				eqExp.push_back(ev);
				eqName.push_back(testName);
				decDue.push_back(cycle + `SLICE_LATENCY);
				decExp.push_back(ffePkg::decisionVec_t'(d));
				decName.push_back(testName);
				tick();
			end
			default: begin
				$display("Unknown line kind in trace: %s", line);
				stopRun();
			end
		endcase
	endtask

	task automatic loadTrace();
		int fd;
		string line;
		fd = $fopen("dv/ffe_trace.txt", "r");
		if (fd == 0) begin
			$display("Could not open the trace file dv/ffe_trace.txt");
			stopRun();
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			// Blank lines and comment lines carry no stimulus
			if (line.len() >= 2 && line[0] != "#") begin
				traceLines.push_back(line);
			end
		end
		$fclose(fd);
	endtask

	initial begin
		codes       = '0;
		cmd         = '0;
		cycle       = 0;
		hostCredits = `CMD_CREDITS;
		failures    = 0;
		testName    = "none";
		cycleLimit  = 100;
		void'($urandom(32'h3ea6_06fc));

		loadTrace();
		cycleLimit = 2 * traceLines.size() + 100;

		@(posedge rstb);
		tick();
		foreach (traceLines[i]) begin
			runLine(traceLines[i]);
		end

		// Every command must come back as exactly one credit
		// A stray pulse in the trailing cycles is caught by tick
		drainChecks();
		while (hostCredits < `CMD_CREDITS) begin
			tick();
		end
		repeat (3) tick();

		if (failures == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// File: dv/ffe_props.sv
`timescale 1ns/1ps
`include "ffe_settings.svh"

module ffeProps (
	input logic               clk,
	input logic               rstb,
	input ffePkg::weightCmd_t cmd,
	input logic               credit,
	input logic               wrEn,
	input logic [`LANE_W-1:0] wrLane,
	input logic [`TAP_W-1:0]  wrTap,
	input ffePkg::weight_t    wrWeight,
	input logic               commit
);

	// Commands accepted minus credits handed back
	int outstanding;

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			outstanding <= 0;
		end else begin
			outstanding <= outstanding + int'(cmd.valid) - int'(credit);
		end
	end

	// Credits only come back for commands that were sent
	// The host may never hold more commands in the queue than it had credits
	assert property (@(posedge clk) disable iff (!rstb)
		(outstanding >= 0) && (outstanding <= `CMD_CREDITS))
		else $error("Outstanding commands outside zero to the queue depth");

	// No credit may leak out while reset is held
	assert property (@(posedge clk) !rstb |-> !credit)
		else $error("Credit pulse during reset");

	// A bank write shares neither the copy edge nor the settle cycle after it
	assert property (@(posedge clk) disable iff (!rstb)
		commit |-> !wrEn ##1 (!wrEn && !commit))
		else $error("Tap write or second commit during a commit or its settle cycle");

	// Every bank write carries the fields latched from the popped command
	assert property (@(posedge clk) disable iff (!rstb)
		wrEn |-> !$isunknown({wrLane, wrTap, wrWeight}))
		else $error("Tap write with unknown lane, tap or weight");

endmodule

bind ffeControl ffeProps ffeProps_i (
	.clk      (clk),
	.rstb     (rstb),
	.cmd      (cmd),
	.credit   (credit),
	.wrEn     (wrEn),
	.wrLane   (wrLane),
	.wrTap    (wrTap),
	.wrWeight (wrWeight),
	.commit   (commit)
);

// File: dv/ffe_trace.txt
# T name | W lane tap weight | C commit | S code0..code3 eq0..eq3 decisions(hex, bit j = lane j)
# Codes, weights and eq are signed decimal, lane 0 oldest
T after_reset
S 10 -20 30 -40 0 0 0 0 f
S 127 -128 5 6 0 0 0 0 f
T pass_through
W 0 0 64
W 1 0 64
W 2 0 64
W 3 0 64
C
S 80 -80 8 -9 10 -10 1 -2 5
S 0 -1 127 -128 0 -1 15 -16 5
T hold_shadow
W 0 1 -32
W 0 2 16
W 0 3 8
W 1 1 -32
W 1 2 16
W 1 3 8
W 2 1 -32
W 2 2 16
W 2 3 8
W 3 1 -32
W 3 2 16
W 3 3 8
S 16 24 -40 8 2 3 -5 1 b
T cross_lane
C
S 0 0 0 64 0 0 0 8 f
S 32 -64 0 16 0 -8 6 0 d
S -128 -128 -128 -128 -18 -8 -12 -14 0
S 100 -100 50 -50 14 -25 13 -11 5

// File: dv/tbClock.sv
`timescale 1ns/1ps

module tbClock (
	output logic clk,
	output logic rstb
);

	// 40 ns period, so each half period is 20 ns
	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	// Reset stays low across the first two rising edges
	initial begin
		rstb = 1'b0;
		repeat (2) @(posedge clk);
		#1 rstb = 1'b1;
	end

endmodule

// File: sim.f
+incdir+verilog
verilog/ffePkg.sv
verilog/ffeControl.sv
verilog/weightBank.sv
verilog/ffe.sv
verilog/slicer.sv
verilog/ffeTop.sv
dv/tbClock.sv
dv/ffe_props.sv
dv/ffeTb.sv

// File: verilog/ffe.sv
`timescale 1ns/1ps
`include "ffe_settings.svh"

module ffe (
	input  logic               clk,
	input  logic               rstb,
	input  ffePkg::codeVec_t   codes,
	input  ffePkg::weightSet_t weights,
	output ffePkg::resultVec_t eq
);

	// Number of code vectors kept so lane 0's oldest tap is still available
	localparam int HIST = (`NUM_TAPS + `NUM_CH - 2) / `NUM_CH + 1;
	// Adder tree depth, with leaves padded up to a power of two
	localparam int LEVELS = $clog2(`NUM_TAPS);
	localparam int LEAVES = 2 ** LEVELS;
	// Flat index of lane 0 in the newest vector
	localparam int NEWEST_BASE = (HIST - 1) * `NUM_CH;

	// hist[0] is the newest vector, hist[HIST-1] the oldest
	ffePkg::codeVec_t   hist [HIST];
	ffePkg::weightSet_t wReg;

	// History laid out in time order, index grows toward newer samples
	ffePkg::code_t flat [HIST*`NUM_CH];

	logic signed [`PROD_W-1:0] prodNext [`NUM_CH][`NUM_TAPS];
	logic signed [`PROD_W-1:0] prodReg  [`NUM_CH][`NUM_TAPS];
	logic signed [`SUM_W-1:0]  leaf     [`NUM_CH][LEAVES];
	logic signed [`SUM_W-1:0]  pairSum  [`NUM_CH][LEVELS][LEAVES/2];
	logic signed [`SUM_W-1:0]  sumReg   [`NUM_CH][LEVELS][LEAVES/2];

	// Flatten so a lane's older taps walk straight across lane and vector edges
	for (genvar v = 0; v < HIST; v++) begin : gHist
		for (genvar c = 0; c < `NUM_CH; c++) begin : gLane
			assign flat[(HIST-1-v)*`NUM_CH + c] = hist[v][c];
		end
	end

	for (genvar j = 0; j < `NUM_CH; j++) begin : gCh
		// Tap t takes the sample t steps older than lane j's newest one
		for (genvar t = 0; t < `NUM_TAPS; t++) begin : gTap
			assign prodNext[j][t] = wReg[j][t] * flat[NEWEST_BASE + j - t];
		end

		// Missing leaves read as zero so the tree stays balanced
		for (genvar i = 0; i < LEAVES; i++) begin : gLeaf
			if (i < `NUM_TAPS) begin : gUsed
				assign leaf[j][i] = `SUM_W'(prodReg[j][i]);
			end else begin : gPad
				assign leaf[j][i] = '0;
			end
		end

		// Level l adds pairs from the level below
		// The first level reads the registered products directly
		for (genvar l = 0; l < LEVELS; l++) begin : gLevel
			for (genvar i = 0; i < (LEAVES >> (l + 1)); i++) begin : gNode
				if (l == 0) begin : gFirst
					assign pairSum[j][l][i] = leaf[j][2*i] + leaf[j][2*i+1];
				end else begin : gInner
					assign pairSum[j][l][i] = sumReg[j][l-1][2*i] + sumReg[j][l-1][2*i+1];
				end
			end
		end
	end

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			hist    <= '{default: '0};
			wReg    <= '0;
			prodReg <= '{default: '0};
			sumReg  <= '{default: '0};
			eq      <= '0;
		end else begin
			// Buffer stage, the oldest vector falls off the end
			hist[0] <= codes;
			for (int v = 1; v < HIST; v++) begin
				hist[v] <= hist[v-1];
			end

			// Weights are sampled here, so a commit reaches the products one edge later
			wReg <= weights;

			for (int j = 0; j < `NUM_CH; j++) begin
				for (int t = 0; t < `NUM_TAPS; t++) begin
					prodReg[j][t] <= prodNext[j][t];
				end

				// Every tree level except the last gets its own register
				for (int l = 0; l < LEVELS - 1; l++) begin
					for (int i = 0; i < (LEAVES >> (l + 1)); i++) begin
						sumReg[j][l][i] <= pairSum[j][l][i];
					end
				end

				// Root level, shifted down and registered as the equalized sample
				eq[j] <= ffePkg::result_t'(pairSum[j][LEVELS-1][0] >>> `RESULT_SHIFT);
			end
		end
	end

endmodule

// File: verilog/ffeControl.sv
`timescale 1ns/1ps
`include "ffe_settings.svh"

module ffeControl (
	input  logic               clk,
	input  logic               rstb,
	input  ffePkg::weightCmd_t cmd,
	output logic               credit,
	output logic               wrEn,
	output logic [`LANE_W-1:0] wrLane,
	output logic [`TAP_W-1:0]  wrTap,
	output ffePkg::weight_t    wrWeight,
	output logic               commit
);

	localparam int PTR_W = (`CMD_CREDITS > 1) ? $clog2(`CMD_CREDITS) : 1;
	localparam int CNT_W = $clog2(`CMD_CREDITS + 1);

	// Write and commit each own a state, so the bank strobes decode directly
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_WRITE,
		ST_COMMIT,
		ST_SETTLE
	} ctrlState_e;

	ctrlState_e state;
	ctrlState_e stateNext;

	ffePkg::weightCmd_t queue [`CMD_CREDITS];
	ffePkg::weightCmd_t head;

	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [CNT_W-1:0] count;
	logic             push;
	logic             pop;

	// Pointers wrap at the queue depth, which need not be a power of two
	function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(`CMD_CREDITS - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// The host only sends while it holds a credit, so a push never finds the queue full
	assign push = cmd.valid;
	assign head = queue[rdPtr];

	// A tap write costs one cycle, so writes may pop back to back
	// Commit and settle both hold the queue
	assign pop = ((state == ST_IDLE) || (state == ST_WRITE)) && (count != '0);

	always_comb begin
		stateNext = state;
		case (state)
			ST_IDLE, ST_WRITE: begin
				stateNext = ST_IDLE;
				if (pop) begin
					case (head.op)
						ffePkg::OP_WRITE_TAP: stateNext = ST_WRITE;
						ffePkg::OP_COMMIT:    stateNext = ST_COMMIT;
						// NOP is dropped here, its credit still goes back
						default:              stateNext = ST_IDLE;
					endcase
				end
			end
			// Extra cycle so a following write cannot land on the copy edge
			ST_COMMIT: stateNext = ST_SETTLE;
			default:   stateNext = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			state  <= ST_IDLE;
			wrPtr  <= '0;
			rdPtr  <= '0;
			count  <= '0;
			credit <= 1'b0;
		end else begin
			state <= stateNext;
			// One credit per removed command, visible the cycle after the pop
			credit <= pop;
			if (push) begin
				wrPtr <= nextPtr(wrPtr);
			end
			if (pop) begin
				rdPtr <= nextPtr(rdPtr);
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Queue storage, and the bank write fields latched from the head entry on each pop
	always_ff @(posedge clk) begin
		if (push) begin
			queue[wrPtr] <= cmd;
		end
		if (pop) begin
			wrLane   <= head.lane;
			wrTap    <= head.tap;
			wrWeight <= head.weight;
		end
	end

	// Strobes are decoded from the registered state and never overlap
	assign wrEn   = (state == ST_WRITE);
	assign commit = (state == ST_COMMIT);

endmodule

// File: verilog/ffePkg.sv
`include "ffe_settings.svh"

package ffePkg;

	// Host command opcodes
	typedef enum logic [1:0] {
		OP_NOP       = 2'd0,
		OP_WRITE_TAP = 2'd1,
		OP_COMMIT    = 2'd2
	} cmdOp_e;

	// Element types are signed so that selecting one lane keeps the sign
	typedef logic signed [`CODE_W-1:0] code_t;
	typedef logic signed [`WEIGHT_W-1:0] weight_t;
	typedef logic signed [`RESULT_W-1:0] result_t;

	// One host command, presented for a single cycle with valid high
	typedef struct packed {
		logic               valid;
		cmdOp_e             op;
		logic [`LANE_W-1:0] lane;
		logic [`TAP_W-1:0]  tap;
		weight_t            weight;
	} weightCmd_t;

	// One code per lane, index 0 is the oldest sample of the vector
	typedef code_t [`NUM_CH-1:0] codeVec_t;

	// Equalized samples in the same lane order as the codes
	typedef result_t [`NUM_CH-1:0] resultVec_t;

	// Weights indexed by lane, then by tap
	// Tap 0 multiplies the lane's own sample, tap t the sample t steps older
	typedef weight_t [`NUM_CH-1:0][`NUM_TAPS-1:0] weightSet_t;

	// One NRZ decision bit per lane
	typedef logic [`NUM_CH-1:0] decisionVec_t;

endpackage

// File: verilog/ffeTop.sv
`timescale 1ns/1ps
`include "ffe_settings.svh"

module ffeTop (
	input  logic                 clk,
	input  logic                 rstb,
	input  ffePkg::codeVec_t     codes,
	input  ffePkg::weightCmd_t   cmd,
	output logic                 credit,
	output ffePkg::resultVec_t   eq,
	output ffePkg::decisionVec_t decisions
);

	// Bank write port, driven by the command sequencer
	logic               wrEn;
	logic [`LANE_W-1:0] wrLane;
	logic [`TAP_W-1:0]  wrTap;
	ffePkg::weight_t    wrWeight;
	logic               commit;

	// Committed weights feeding the FIR
	ffePkg::weightSet_t activeWeights;

	// Host commands enter here under credit flow control
	ffeControl ffeControl_i (
		.clk      (clk),
		.rstb     (rstb),
		.cmd      (cmd),
		.credit   (credit),
		.wrEn     (wrEn),
		.wrLane   (wrLane),
		.wrTap    (wrTap),
		.wrWeight (wrWeight),
		.commit   (commit)
	);

	weightBank weightBank_i (
		.clk      (clk),
		.rstb     (rstb),
		.wrEn     (wrEn),
		.wrLane   (wrLane),
		.wrTap    (wrTap),
		.wrWeight (wrWeight),
		.commit   (commit),
		.active   (activeWeights)
	);

	// Sample path runs every cycle with no back-pressure
	ffe ffe_i (
		.clk     (clk),
		.rstb    (rstb),
		.codes   (codes),
		.weights (activeWeights),
		.eq      (eq)
	);

	slicer slicer_i (
		.clk       (clk),
		.rstb      (rstb),
		.eq        (eq),
		.decisions (decisions)
	);

endmodule

// File: verilog/ffe_settings.svh
`ifndef FFE_SETTINGS_SVH
`define FFE_SETTINGS_SVH

// Lanes delivered per clock, lane 0 oldest
`define NUM_CH 4
// FIR taps per lane
`define NUM_TAPS 4

// Signed widths of ADC codes, tap weights and equalized samples
`define CODE_W 8
`define WEIGHT_W 8
`define RESULT_W 8

// Command field widths, wide enough to address every lane and tap
`define LANE_W 2
`define TAP_W 2

// Full product keeps one sign bit, the sum grows by one bit per tree level
`define PROD_W (`CODE_W + `WEIGHT_W - 1)
`define SUM_W (`PROD_W + $clog2(`NUM_TAPS))
`define RESULT_SHIFT (`SUM_W - `RESULT_W)

// Command queue depth, also the credits the host owns after reset
`define CMD_CREDITS 2

// Buffer stage, product stage, then one register per adder-tree level
`define FFE_LATENCY (2 + $clog2(`NUM_TAPS))
`define SLICE_LATENCY (`FFE_LATENCY + 1)

`endif

// File: verilog/slicer.sv
`timescale 1ns/1ps
`include "ffe_settings.svh"

module slicer (
	input  logic                 clk,
	input  logic                 rstb,
	input  ffePkg::resultVec_t   eq,
	output ffePkg::decisionVec_t decisions
);

	// NRZ threshold sits at zero
	// A lane decides 1 for zero or positive samples, 0 for negative ones

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			decisions <= '0;
		end else begin
			for (int j = 0; j < `NUM_CH; j++) begin
				// Sign bit alone settles the decision
				decisions[j] <= ~eq[j][`RESULT_W-1];
			end
		end
	end

endmodule

// File: verilog/weightBank.sv
`timescale 1ns/1ps
`include "ffe_settings.svh"

module weightBank (
	input  logic                clk,
	input  logic                rstb,
	input  logic                wrEn,
	input  logic [`LANE_W-1:0]  wrLane,
	input  logic [`TAP_W-1:0]   wrTap,
	input  ffePkg::weight_t     wrWeight,
	input  logic                commit,
	output ffePkg::weightSet_t  active
);

	// Host-side copy, built up one tap at a time
	ffePkg::weightSet_t shadow;

	// The equalizer only ever reads the active copy
	// A half-written tap set in the shadow therefore never reaches the FIR

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			// Equalizer output stays zero until the host commits real weights
			shadow <= '0;
			active <= '0;
		end else begin
			// Single tap update, addressed by lane and tap
			if (wrEn) begin
				shadow[wrLane][wrTap] <= wrWeight;
			end

			// Whole set moves in one edge
			// Control never raises wrEn and commit together, so the copy
			// always sees a shadow that is stable for this edge
			if (commit) begin
				active <= shadow;
			end
		end
	end

endmodule
